//--- hdl/credit_fifo_pkg.sv
// Fixed 8-bit payload and 3-stage links; FIFO depth follows from the link latencies
`default_nettype none

package credit_fifo_pkg;

  localparam int DATA_WIDTH = 8;
  localparam int LINK_DELAY = 3;

  // Push handshake to pop_valid on an empty FIFO
  localparam int CUT_THROUGH_LATENCY = LINK_DELAY + 1;
  // Pop handshake to sender credit increment
  localparam int BACKPRESSURE_LATENCY = LINK_DELAY + 1;

  // Enough entries to cover the whole credit loop at full rate
  localparam int FIFO_DEPTH = CUT_THROUGH_LATENCY + BACKPRESSURE_LATENCY + 1;

  localparam int COUNT_WIDTH = $clog2(FIFO_DEPTH + 1);
  localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH);

  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [COUNT_WIDTH-1:0] count_t;

  typedef struct packed {
    logic  valid;
    data_t data;
    logic  sender_in_reset;
  } fwd_link_t;

  typedef struct packed {
    logic credit;
    logic receiver_in_reset;
  } rev_link_t;

  // Link registers come out of reset idle, with the in-reset flags set
  localparam fwd_link_t FWD_LINK_RESET = '{valid: 1'b0, data: '0, sender_in_reset: 1'b1};
  localparam rev_link_t REV_LINK_RESET = '{credit: 1'b0, receiver_in_reset: 1'b1};

endpackage

`default_nettype wire

//--- hdl/link_delay.sv
// Pure register pipeline; every stage loads ResetValue while rst_n is low
`default_nettype none

module link_delay #(
  parameter type payload_t = logic,
  parameter int NumStages = 1,
  parameter payload_t ResetValue = payload_t'(0)
) (
  input  wire      clk,
  input  wire      rst_n,
  input  payload_t in,
  output payload_t out
);

  if (NumStages < 1) begin : gen_bad_stages
    $error("link_delay needs at least one stage");
  end

  payload_t stages [NumStages];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NumStages; i++) begin
        stages[i] <= ResetValue;
      end
    end else begin
      stages[0] <= in;
      for (int i = 1; i < NumStages; i++) begin
        stages[i] <= stages[i-1];
      end
    end
  end

  assign out = stages[NumStages-1];

endmodule

`default_nettype wire

//--- hdl/credit_sender.sv
// Starts with zero credit; push_ready stays low until the receiver returns its credits
`default_nettype none

module credit_sender
  import credit_fifo_pkg::*;
(
  input  wire       clk,
  input  wire       rst_n,
  input  logic      push_valid,
  output logic      push_ready,
  input  data_t     push_data,
  output fwd_link_t fwd,
  input  rev_link_t rev,
  output count_t    credit_count
);

  localparam count_t MAX_CREDIT = count_t'(FIFO_DEPTH);

  logic   push_hs;
  logic   sender_in_reset;
  logic   receiver_in_reset;
  count_t credit_next;

  // High through reset, drops on the first edge after release
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sender_in_reset <= 1'b1;
    end else begin
      sender_in_reset <= 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      receiver_in_reset <= 1'b1;
    end else begin
      receiver_in_reset <= rev.receiver_in_reset;
    end
  end

  assign push_ready = (credit_count != '0) && !receiver_in_reset;
  assign push_hs = push_valid && push_ready;

  // Returned credit and a spent credit in one cycle cancel out
  always_comb begin
    credit_next = credit_count;
    if (rev.credit && !push_hs) begin
      if (credit_count != MAX_CREDIT) begin
        credit_next = credit_count + 1'b1;
      end
    end else if (!rev.credit && push_hs) begin
      credit_next = credit_count - 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credit_count <= '0;
    end else begin
      credit_count <= credit_next;
    end
  end

  assign fwd = '{valid: push_hs, data: push_data, sender_in_reset: sender_in_reset};

endmodule

`default_nettype wire

//--- hdl/fifo_flops_push_credit.sv
// No overflow check on push; the credit loop alone keeps writes within FIFO_DEPTH
`default_nettype none

module fifo_flops_push_credit
  import credit_fifo_pkg::*;
(
  input  wire       clk,
  input  wire       rst_n,
  input  fwd_link_t fwd,
  output rev_link_t rev,
  output logic      pop_valid,
  input  logic      pop_ready,
  output data_t     pop_data,
  output logic      full,
  output logic      empty,
  output count_t    items,
  output count_t    slots
);

  localparam count_t DEPTH_COUNT = count_t'(FIFO_DEPTH);
  localparam logic [ADDR_WIDTH-1:0] LAST_ADDR = ADDR_WIDTH'(FIFO_DEPTH - 1);

  data_t                 mem [FIFO_DEPTH];
  logic [ADDR_WIDTH-1:0] wr_ptr;
  logic [ADDR_WIDTH-1:0] rd_ptr;
  logic                  push;
  logic                  pop;
  logic                  receiver_in_reset;
  logic                  init_credit_done;
  logic                  credit_pulse;
  logic                  credit_issue;
  count_t                credit_pending;

  function automatic logic [ADDR_WIDTH-1:0] next_ptr(input logic [ADDR_WIDTH-1:0] ptr);
    return (ptr == LAST_ADDR) ? '0 : ptr + 1'b1;
  endfunction

  assign push = fwd.valid;
  assign pop = pop_valid && pop_ready;

  // Payload storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= fwd.data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      items  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      if (push && !pop) begin
        items <= items + 1'b1;
      end else if (!push && pop) begin
        items <= items - 1'b1;
      end
    end
  end

  assign pop_valid = (items != '0);
  assign pop_data = mem[rd_ptr];
  assign empty = (items == '0);
  assign full = (items == DEPTH_COUNT);
  assign slots = DEPTH_COUNT - items;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      receiver_in_reset <= 1'b1;
    end else begin
      receiver_in_reset <= 1'b0;
    end
  end

  // A pop can go straight out as a credit, so the pulse follows it by one cycle
  assign credit_issue = !fwd.sender_in_reset && (pop || credit_pending != '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      init_credit_done <= 1'b0;
      credit_pending   <= '0;
      credit_pulse     <= 1'b0;
    end else if (!init_credit_done) begin
      credit_pulse <= 1'b0;
      if (!fwd.sender_in_reset) begin
        // Whole depth goes back once the sender is up
        init_credit_done <= 1'b1;
        credit_pending   <= DEPTH_COUNT;
      end
    end else begin
      credit_pulse <= credit_issue;
      if (pop && !credit_issue) begin
        credit_pending <= credit_pending + 1'b1;
      end else if (!pop && credit_issue) begin
        credit_pending <= credit_pending - 1'b1;
      end
    end
  end

  assign rev = '{credit: credit_pulse, receiver_in_reset: receiver_in_reset};

endmodule

`default_nettype wire

//--- hdl/credit_fifo_top.sv
// Single clock and reset; both link directions use the same LINK_DELAY depth
`default_nettype none

module credit_fifo_top
  import credit_fifo_pkg::*;
(
  input  wire    clk,
  input  wire    rst_n,
  input  logic   push_valid,
  output logic   push_ready,
  input  data_t  push_data,
  output logic   pop_valid,
  input  logic   pop_ready,
  output data_t  pop_data,
  output logic   full,
  output logic   empty,
  output count_t items,
  output count_t slots,
  output count_t sender_credit
);

  fwd_link_t fwd_near;
  fwd_link_t fwd_far;
  rev_link_t rev_near;
  rev_link_t rev_far;

  credit_sender credit_sender_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .push_valid   (push_valid),
    .push_ready   (push_ready),
    .push_data    (push_data),
    .fwd          (fwd_near),
    .rev          (rev_near),
    .credit_count (sender_credit)
  );

  // Sender to FIFO
  link_delay #(
    .payload_t  (fwd_link_t),
    .NumStages  (LINK_DELAY),
    .ResetValue (FWD_LINK_RESET)
  ) link_delay_fwd (
    .clk   (clk),
    .rst_n (rst_n),
    .in    (fwd_near),
    .out   (fwd_far)
  );

  // FIFO back to sender
  link_delay #(
    .payload_t  (rev_link_t),
    .NumStages  (LINK_DELAY),
    .ResetValue (REV_LINK_RESET)
  ) link_delay_rev (
    .clk   (clk),
    .rst_n (rst_n),
    .in    (rev_far),
    .out   (rev_near)
  );

  fifo_flops_push_credit fifo_flops_push_credit_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .fwd       (fwd_far),
    .rev       (rev_far),
    .pop_valid (pop_valid),
    .pop_ready (pop_ready),
    .pop_data  (pop_data),
    .full      (full),
    .empty     (empty),
    .items     (items),
    .slots     (slots)
  );

endmodule

`default_nettype wire

//--- tests/tb_clock_gen.sv
// Free-running 4 ns clock; rst_n is released 1 ns after the 16th rising edge
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic rst_n
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int RESET_CYCLES = 16;

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

//--- tests/credit_fifo_assert.sv
// Port-level checks on credit_fifo_top; all properties are off while rst_n is low
`default_nettype none

module credit_fifo_assert
  import credit_fifo_pkg::*;
(
  input wire    clk,
  input wire    rst_n,
  input logic   push_valid,
  input logic   push_ready,
  input logic   pop_valid,
  input logic   pop_ready,
  input data_t  pop_data,
  input logic   full,
  input logic   empty,
  input count_t items,
  input count_t slots,
  input count_t sender_credit
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int QUIET_CYCLES = CUT_THROUGH_LATENCY - 1;

  int unsigned fail_count = 0;

  status_sum: assert property (@(posedge clk) disable iff (!rst_n)
    (int'(items) + int'(slots)) == FIFO_DEPTH
  ) else begin
    $error("items plus slots differs from the FIFO depth");
    fail_count++;
  end

  status_flags: assert property (@(posedge clk) disable iff (!rst_n)
    (empty == (items == '0)) && (full == (slots == '0))
  ) else begin
    $error("empty or full disagrees with the counters");
    fail_count++;
  end

  // Idle loop with all credits home, so nothing else is in flight
  cut_through: assert property (@(posedge clk) disable iff (!rst_n)
    push_valid && push_ready && empty && pop_ready && sender_credit == count_t'(FIFO_DEPTH)
    |=> !pop_valid [*QUIET_CYCLES] ##1 pop_valid
  ) else begin
    $error("pop_valid did not follow the push after the cut-through latency");
    fail_count++;
  end

  pop_hold: assert property (@(posedge clk) disable iff (!rst_n)
    pop_valid && !pop_ready |=> pop_valid && $stable(pop_data)
  ) else begin
    $error("pop_valid or pop_data changed before pop_ready");
    fail_count++;
  end

endmodule

bind credit_fifo_top credit_fifo_assert credit_fifo_assert_inst (.*);

`default_nettype wire

//--- tests/credit_fifo_tb.sv
// Outputs are sampled on the falling edge; inputs change 1 ns after the rising edge
`default_nettype none

module credit_fifo_tb
  import credit_fifo_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int SEED = 54795;
  localparam int RANDOM_WORDS = 100;
  localparam int WAIT_LIMIT = 200;
  localparam int STREAM_LIMIT = 2000;

  logic   clk;
  logic   rst_n;
  logic   push_valid;
  logic   push_ready;
  data_t  push_data;
  logic   pop_valid;
  logic   pop_ready;
  data_t  pop_data;
  logic   full;
  logic   empty;
  count_t items;
  count_t slots;
  count_t sender_credit;

  data_t  expected_q[$];
  data_t  expected_word;
  int     push_total = 0;
  int     pop_total = 0;
  int     mismatches = 0;
  int     timeouts = 0;
  int     assert_fails;
  int     cycles;
  int     sent;

  tb_clock_gen tb_clock_gen_inst (.clk(clk), .rst_n(rst_n));

  credit_fifo_top credit_fifo_top_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .push_valid    (push_valid),
    .push_ready    (push_ready),
    .push_data     (push_data),
    .pop_valid     (pop_valid),
    .pop_ready     (pop_ready),
    .pop_data      (pop_data),
    .full          (full),
    .empty         (empty),
    .items         (items),
    .slots         (slots),
    .sender_credit (sender_credit)
  );

  task automatic after_rising_edge();
    @(posedge clk);
    #1;
  endtask

  task automatic note_timeout(input string what);
    $display("timeout at %0t: %s", $time, what);
    timeouts++;
  endtask

  task automatic compare_int(input string what, input int got, input int exp);
    if (got != exp) begin
      $display("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
      mismatches++;
    end
  endtask

  // Scoreboard follows every handshake on both sides
  always @(negedge clk) begin
    if (rst_n) begin
      if (push_valid && push_ready) begin
        expected_q.push_back(push_data);
        push_total++;
      end
      if (pop_valid && pop_ready) begin
        pop_total++;
        if (expected_q.size() == 0) begin
          $display("mismatch at %0t: pop of %h with nothing pushed", $time, pop_data);
          mismatches++;
        end else begin
          expected_word = expected_q.pop_front();
          if (pop_data !== expected_word) begin
            $display("mismatch at %0t: popped %h, expected %h", $time, pop_data, expected_word);
            mismatches++;
          end
        end
      end
    end
  end

  initial begin
    push_valid = 1'b0;
    push_data = '0;
    pop_ready = 1'b0;
    void'($urandom(SEED));

    cycles = 0;
    while (!rst_n && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (!rst_n) note_timeout("rst_n was never released");

    // Initial credit return
    cycles = 0;
    while (sender_credit != count_t'(FIFO_DEPTH) && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      if (sender_credit == '0) compare_int("push_ready with no credit", int'(push_ready), 0);
      cycles++;
    end
    if (sender_credit != count_t'(FIFO_DEPTH)) note_timeout("initial credits never arrived");

    // Consumer stalled, producer always valid
    sent = push_total;
    after_rising_edge();
    push_valid = 1'b1;
    for (int i = 0; i < 3 * FIFO_DEPTH; i++) begin
      push_data = data_t'($urandom);
      after_rising_edge();
    end
    push_valid = 1'b0;
    cycles = 0;
    while (!full && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (!full) note_timeout("full never rose with pop_ready low");
    @(negedge clk);
    compare_int("pushes accepted while stalled", push_total - sent, FIFO_DEPTH);
    compare_int("items when full", int'(items), FIFO_DEPTH);
    compare_int("push_ready when full", int'(push_ready), 0);

    // Random traffic on both sides
    sent = 0;
    cycles = 0;
    while (sent < RANDOM_WORDS && cycles < STREAM_LIMIT) begin
      after_rising_edge();
      push_valid = 1'($urandom_range(1, 0));
      push_data = data_t'($urandom);
      pop_ready = 1'($urandom_range(1, 0));
      @(negedge clk);
      if (push_valid && push_ready) sent++;
      cycles++;
    end
    if (sent < RANDOM_WORDS) note_timeout("random words were not all accepted");

    for (int pass = 0; pass < 2; pass++) begin
      after_rising_edge();
      push_valid = 1'b0;
      pop_ready = 1'b1;
      cycles = 0;
      while ((expected_q.size() != 0 || !empty) && cycles < WAIT_LIMIT) begin
        @(negedge clk);
        cycles++;
      end
      if (expected_q.size() != 0 || !empty) note_timeout("FIFO did not drain");
      cycles = 0;
      while (sender_credit != count_t'(FIFO_DEPTH) && cycles < WAIT_LIMIT) begin
        @(negedge clk);
        cycles++;
      end
      if (sender_credit != count_t'(FIFO_DEPTH)) note_timeout("credits did not all return");
      // Then one lone word through the idle FIFO
      if (pass == 0) begin
        after_rising_edge();
        push_valid = 1'b1;
        push_data = data_t'($urandom);
      end
    end

    compare_int("words left in scoreboard", expected_q.size(), 0);
    compare_int("pops against pushes", pop_total, push_total);
    assert_fails = credit_fifo_top_inst.credit_fifo_assert_inst.fail_count;
    $display("closing report: %0d mismatches, %0d timeouts, %0d assertion failures",
             mismatches, timeouts, assert_fails);
    if (mismatches == 0 && timeouts == 0 && assert_fails == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
hdl/credit_fifo_pkg.sv
hdl/link_delay.sv
hdl/credit_sender.sv
hdl/fifo_flops_push_credit.sv
hdl/credit_fifo_top.sv
tests/tb_clock_gen.sv
tests/credit_fifo_assert.sv
tests/credit_fifo_tb.sv

//--- Bender.yml
package:
  name: credit_fifo

sources:
  - files:
      - hdl/credit_fifo_pkg.sv
      - hdl/link_delay.sv
      - hdl/credit_sender.sv
      - hdl/fifo_flops_push_credit.sv
      - hdl/credit_fifo_top.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/credit_fifo_assert.sv
      - tests/credit_fifo_tb.sv
